//--- byte_to_word_fcs_sn_insert.sv
// byte to word packer with partial word flush and fcs / sequence number trailer
`timescale 1ns/1ps
`default_nettype none

module byte_to_word_fcs_sn_insert (
    input  wire                 m00_axis_aclk,
    input  wire                 rst_n,
    input  wire                 pkt_header_valid_strobe,
    input  wire rx_intf_pkg::byte_t byte_in,
    input  wire                 byte_in_strobe,
    input  wire                 fcs_in_strobe,
    input  wire                 fcs_ok,
    input  wire                 sn_advance,
    output rx_intf_pkg::word_t  word_out,
    output logic                word_strobe,
    output logic                trail_strobe
);
    import rx_intf_pkg::*;

    localparam int IDX_W = $clog2(WORD_BYTES);

    logic [IDX_W-1:0] byte_idx;
    word_t            acc;
    word_t            acc_nxt;
    logic             trail_pending;
    logic             fcs_ok_q;
    sn_t              sn;

    // new byte merged into the partial word, low byte first
    always_comb
    begin
        acc_nxt = acc;
        acc_nxt[{byte_idx, 3'b000} +: 8] = byte_in;
    end

    // trailer word built from the fcs verdict and the running sequence number
    function automatic word_t make_trailer(input logic ok, input sn_t seq);
        word_t w;
        w = '0;
        w[TRAIL_SN_LSB +: $bits(sn_t)] = seq;
        w[TRAIL_FCS_BIT] = ok;
        return w;
    endfunction

    // control state
    always_ff @(posedge m00_axis_aclk)
    begin
        if (!rst_n)
        begin
            byte_idx      <= '0;
            trail_pending <= 1'b0;
            word_strobe   <= 1'b0;
            trail_strobe  <= 1'b0;
        end
        else
        begin
            word_strobe  <= 1'b0;
            trail_strobe <= 1'b0;
            if (pkt_header_valid_strobe)
            begin
                byte_idx      <= '0;
                trail_pending <= 1'b0;
            end
            else if (byte_in_strobe)
            begin
                byte_idx <= byte_idx + 1'b1;
                if (byte_idx == IDX_W'(WORD_BYTES - 1))
                    word_strobe <= 1'b1;
            end
            else if (fcs_in_strobe)
            begin
                byte_idx <= '0;
                // flush partial word first, trailer follows a cycle later
                if (byte_idx != '0)
                begin
                    word_strobe   <= 1'b1;
                    trail_pending <= 1'b1;
                end
                else
                    trail_strobe <= 1'b1;
            end
            else if (trail_pending)
            begin
                trail_pending <= 1'b0;
                trail_strobe  <= 1'b1;
            end
        end
    end

    // word data path
    always_ff @(posedge m00_axis_aclk)
    begin
        if (pkt_header_valid_strobe)
            acc <= '0;
        else if (byte_in_strobe)
        begin
            if (byte_idx == IDX_W'(WORD_BYTES - 1))
            begin
                word_out <= acc_nxt;
                acc      <= '0;
            end
            else
                acc <= acc_nxt;
        end
        else if (fcs_in_strobe)
        begin
            fcs_ok_q <= fcs_ok;
            acc      <= '0;
            if (byte_idx != '0)
                word_out <= acc;
            else
                word_out <= make_trailer(fcs_ok, sn);
        end
        else if (trail_pending)
            word_out <= make_trailer(fcs_ok_q, sn);
    end

    // sequence number moves only for committed packets
    always_ff @(posedge m00_axis_aclk)
    begin
        if (!rst_n)
            sn <= '0;
        else if (sn_advance)
            sn <= sn + 1'b1;
    end

endmodule

`default_nettype wire

//--- compile.f
rx_intf_pkg.sv
byte_to_word_fcs_sn_insert.sv
rx_pkt_framer.sv
rx_pkt_fifo.sv
rx_intf_m_axis.sv
rx_intf.sv
tb_rx_intf.sv

//--- rx_intf.sv
// rx interface top: packer, framer, packet fifo and stream output
`timescale 1ns/1ps
`default_nettype none

module rx_intf (
    input  wire                      m00_axis_aclk,
    input  wire                      rst_n,
    input  wire                      pkt_header_valid,
    input  wire                      pkt_header_valid_strobe,
    input  wire                      ht_unsupport,
    input  wire rx_intf_pkg::rate_t    pkt_rate,
    input  wire rx_intf_pkg::pkt_len_t pkt_len,
    input  wire rx_intf_pkg::byte_t    byte_in,
    input  wire                      byte_in_strobe,
    input  wire                      fcs_in_strobe,
    input  wire                      fcs_ok,
    input  wire                      block_rx_dma_to_ps,
    input  wire                      block_rx_dma_to_ps_valid,
    input  wire rx_intf_pkg::rssi_t    rssi_half_db_lock_by_sig_valid,
    input  wire rx_intf_pkg::gpio_t    gpio_status_lock_by_sig_valid,
    input  wire rx_intf_pkg::tsf_t     tsf_runtime_val,
    input  wire                      keep_bad_fcs,
    output wire                      m00_axis_tvalid,
    output rx_intf_pkg::word_t       m00_axis_tdata,
    output wire                      m00_axis_tlast,
    input  wire                      m00_axis_tready,
    output wire                      rx_pkt_intr
);
    import rx_intf_pkg::*;

    // packer to framer
    word_t       word_out;
    wire         word_strobe;
    wire         trail_strobe;
    wire         sn_advance;

    // framer to fifo
    wire         wr_en;
    fifo_entry_t wr_data;
    wire         commit;
    wire         discard;
    wire         full;

    // fifo to stream stage
    wire         rd_en;
    wire         rd_valid;
    fifo_entry_t rd_data;

    byte_to_word_fcs_sn_insert i_byte_to_word_fcs_sn_insert (
        .m00_axis_aclk           (m00_axis_aclk),
        .rst_n                   (rst_n),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .sn_advance              (sn_advance),
        .word_out                (word_out),
        .word_strobe             (word_strobe),
        .trail_strobe            (trail_strobe)
    );

    rx_pkt_framer i_rx_pkt_framer (
        .m00_axis_aclk                  (m00_axis_aclk),
        .rst_n                          (rst_n),
        .pkt_header_valid               (pkt_header_valid),
        .pkt_header_valid_strobe        (pkt_header_valid_strobe),
        .ht_unsupport                   (ht_unsupport),
        .pkt_rate                       (pkt_rate),
        .pkt_len                        (pkt_len),
        .rssi_half_db_lock_by_sig_valid (rssi_half_db_lock_by_sig_valid),
        .gpio_status_lock_by_sig_valid  (gpio_status_lock_by_sig_valid),
        .tsf_runtime_val                (tsf_runtime_val),
        .block_rx_dma_to_ps             (block_rx_dma_to_ps),
        .block_rx_dma_to_ps_valid       (block_rx_dma_to_ps_valid),
        .keep_bad_fcs                   (keep_bad_fcs),
        .word_out                       (word_out),
        .word_strobe                    (word_strobe),
        .trail_strobe                   (trail_strobe),
        .full                           (full),
        .wr_en                          (wr_en),
        .wr_data                        (wr_data),
        .commit                         (commit),
        .discard                        (discard),
        .sn_advance                     (sn_advance)
    );

    rx_pkt_fifo i_rx_pkt_fifo (
        .m00_axis_aclk (m00_axis_aclk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .commit        (commit),
        .discard       (discard),
        .full          (full),
        .rd_en         (rd_en),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

    rx_intf_m_axis i_rx_intf_m_axis (
        .m00_axis_aclk   (m00_axis_aclk),
        .rst_n           (rst_n),
        .rd_valid        (rd_valid),
        .rd_data         (rd_data),
        .rd_en           (rd_en),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tlast  (m00_axis_tlast),
        .m00_axis_tready (m00_axis_tready),
        .rx_pkt_intr     (rx_pkt_intr)
    );

endmodule

`default_nettype wire

//--- rx_intf_m_axis.sv
// axi stream output register stage and packet interrupt
`timescale 1ns/1ps
`default_nettype none

module rx_intf_m_axis (
    input  wire                         m00_axis_aclk,
    input  wire                         rst_n,
    input  wire                         rd_valid,
    input  wire rx_intf_pkg::fifo_entry_t rd_data,
    output logic                        rd_en,
    output logic                        m00_axis_tvalid,
    output rx_intf_pkg::word_t          m00_axis_tdata,
    output logic                        m00_axis_tlast,
    input  wire                         m00_axis_tready,
    output logic                        rx_pkt_intr
);
    import rx_intf_pkg::*;

    logic load;
    logic hs;

    assign hs = m00_axis_tvalid & m00_axis_tready;

    // refill when empty or when the current word leaves
    assign load  = rd_valid & (~m00_axis_tvalid | m00_axis_tready);
    assign rd_en = load;

    always_ff @(posedge m00_axis_aclk)
    begin
        if (!rst_n)
        begin
            m00_axis_tvalid <= 1'b0;
            rx_pkt_intr     <= 1'b0;
        end
        else
        begin
            if (load)
                m00_axis_tvalid <= 1'b1;
            else if (m00_axis_tready)
                m00_axis_tvalid <= 1'b0;
            // one pulse per delivered packet
            rx_pkt_intr <= hs & m00_axis_tlast;
        end
    end

    // data and last hold while tready is low
    always_ff @(posedge m00_axis_aclk)
    begin
        if (load)
        begin
            m00_axis_tdata <= rd_data[$bits(word_t)-1:0];
            m00_axis_tlast <= rd_data[$bits(word_t)];
        end
    end

endmodule

`default_nettype wire

//--- rx_intf_pkg.sv
// widths, vector types, header field positions, fifo sizing and framer states for the rx path
`default_nettype none

package rx_intf_pkg;

    // word packing
    localparam int WORD_BYTES = 8;

    // packet fifo sizing
    localparam int FIFO_ADDR_W = 6;
    localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;

    // second header word layout
    localparam int HDR_LEN_LSB  = 0;
    localparam int HDR_RATE_LSB = 16;
    localparam int HDR_RSSI_LSB = 24;
    localparam int HDR_GPIO_LSB = 35;

    // trailer word layout
    localparam int TRAIL_SN_LSB  = 0;
    localparam int TRAIL_FCS_BIT = 16;

    typedef logic [7:0]  byte_t;
    typedef logic [63:0] word_t;

    // word plus last flag in the msb
    typedef logic [64:0] fifo_entry_t;

    typedef logic [15:0] pkt_len_t;
    typedef logic [7:0]  rate_t;

    // rssi in half db steps
    typedef logic [10:0] rssi_t;
    typedef logic [7:0]  gpio_t;
    typedef logic [63:0] tsf_t;
    typedef logic [15:0] sn_t;

    typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;

    // extra bit tells full from empty
    typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

    typedef enum logic [2:0] {
        IDLE,
        HDR0,
        HDR1,
        BODY,
        TRAIL
    } framer_state_t;

endpackage

`default_nettype wire

//--- rx_pkt_fifo.sv
// packet fifo with tentative write pointer, committed pointer and read pointer
`timescale 1ns/1ps
`default_nettype none

module rx_pkt_fifo (
    input  wire                         m00_axis_aclk,
    input  wire                         rst_n,
    input  wire                         wr_en,
    input  wire rx_intf_pkg::fifo_entry_t wr_data,
    input  wire                         commit,
    input  wire                         discard,
    output logic                        full,
    input  wire                         rd_en,
    output logic                        rd_valid,
    output rx_intf_pkg::fifo_entry_t    rd_data
);
    import rx_intf_pkg::*;

    fifo_entry_t mem [FIFO_DEPTH];

    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  cmt_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_ptr_t  wr_ptr_nxt;
    fifo_addr_t wr_addr;
    fifo_addr_t rd_addr;
    logic       wr_ok;

    assign wr_addr = wr_ptr[FIFO_ADDR_W-1:0];
    assign rd_addr = rd_ptr[FIFO_ADDR_W-1:0];

    // uncommitted words count against space
    assign full = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) && (wr_addr == rd_addr);

    // reader only sees committed packets
    assign rd_valid = (cmt_ptr != rd_ptr);
    assign rd_data  = mem[rd_addr];

    assign wr_ok      = wr_en & ~full;
    assign wr_ptr_nxt = wr_ok ? wr_ptr + 1'b1 : wr_ptr;

    always_ff @(posedge m00_axis_aclk)
    begin
        if (wr_ok)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            cmt_ptr <= '0;
        end
        else
        begin
            // rewind to last packet boundary
            if (discard)
                wr_ptr <= cmt_ptr;
            else
                wr_ptr <= wr_ptr_nxt;
            // commit includes a word written in the same cycle
            if (commit && !discard)
                cmt_ptr <= wr_ptr_nxt;
        end
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (!rst_n)
            rd_ptr <= '0;
        else if (rd_en && rd_valid)
            rd_ptr <= rd_ptr + 1'b1;
    end

endmodule

`default_nettype wire

//--- rx_pkt_framer.sv
// packet framer: header words, body forwarding, trailer with commit or discard
`timescale 1ns/1ps
`default_nettype none

module rx_pkt_framer (
    input  wire                      m00_axis_aclk,
    input  wire                      rst_n,
    input  wire                      pkt_header_valid,
    input  wire                      pkt_header_valid_strobe,
    input  wire                      ht_unsupport,
    input  wire rx_intf_pkg::rate_t    pkt_rate,
    input  wire rx_intf_pkg::pkt_len_t pkt_len,
    input  wire rx_intf_pkg::rssi_t    rssi_half_db_lock_by_sig_valid,
    input  wire rx_intf_pkg::gpio_t    gpio_status_lock_by_sig_valid,
    input  wire rx_intf_pkg::tsf_t     tsf_runtime_val,
    input  wire                      block_rx_dma_to_ps,
    input  wire                      block_rx_dma_to_ps_valid,
    input  wire                      keep_bad_fcs,
    input  wire rx_intf_pkg::word_t    word_out,
    input  wire                      word_strobe,
    input  wire                      trail_strobe,
    input  wire                      full,
    output logic                     wr_en,
    output rx_intf_pkg::fifo_entry_t wr_data,
    output logic                     commit,
    output logic                     discard,
    output logic                     sn_advance
);
    import rx_intf_pkg::*;

    framer_state_t state;

    // fields latched at the signal-valid event
    tsf_t     tsf_q;
    pkt_len_t len_q;
    rate_t    rate_q;
    rssi_t    rssi_q;
    gpio_t    gpio_q;
    word_t    trail_q;

    // drop reasons collected while the packet is open
    logic block_q;
    logic ovf_q;

    logic  sig_valid;
    logic  pkt_open;
    logic  keep_pkt;
    word_t hdr1;

    assign sig_valid = pkt_header_valid_strobe & pkt_header_valid;
    assign pkt_open  = (state == HDR0) || (state == HDR1) || (state == BODY);

    // trailer write itself must not hit a full fifo
    assign keep_pkt = (trail_q[TRAIL_FCS_BIT] | keep_bad_fcs) & ~block_q & ~ovf_q & ~full;

    always_comb
    begin
        hdr1 = '0;
        hdr1[HDR_LEN_LSB  +: $bits(pkt_len_t)] = len_q;
        hdr1[HDR_RATE_LSB +: $bits(rate_t)]    = rate_q;
        hdr1[HDR_RSSI_LSB +: $bits(rssi_t)]    = rssi_q;
        hdr1[HDR_GPIO_LSB +: $bits(gpio_t)]    = gpio_q;
    end

    always_comb
    begin
        wr_en      = 1'b0;
        wr_data    = '0;
        commit     = 1'b0;
        discard    = 1'b0;
        sn_advance = 1'b0;
        case (state)
            HDR0:
            begin
                wr_en   = 1'b1;
                wr_data = {1'b0, tsf_q};
            end
            HDR1:
            begin
                wr_en   = 1'b1;
                wr_data = {1'b0, hdr1};
            end
            BODY:
            begin
                wr_en   = word_strobe;
                wr_data = {1'b0, word_out};
            end
            TRAIL:
            begin
                wr_en      = 1'b1;
                wr_data    = {1'b1, trail_q};
                commit     = keep_pkt;
                discard    = ~keep_pkt;
                sn_advance = keep_pkt;
            end
            default:
            begin
                wr_en = 1'b0;
            end
        endcase
        // a new signal field kills whatever is still open
        if (pkt_open && sig_valid)
            discard = 1'b1;
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            block_q <= 1'b0;
            ovf_q   <= 1'b0;
        end
        else if (sig_valid)
        begin
            state   <= ht_unsupport ? IDLE : HDR0;
            block_q <= 1'b0;
            ovf_q   <= 1'b0;
        end
        else
        begin
            case (state)
                HDR0:    state <= HDR1;
                HDR1:    state <= BODY;
                BODY:    state <= trail_strobe ? TRAIL : BODY;
                TRAIL:   state <= IDLE;
                default: state <= IDLE;
            endcase
            if (block_rx_dma_to_ps_valid && block_rx_dma_to_ps)
                block_q <= 1'b1;
            if (wr_en && full)
                ovf_q <= 1'b1;
        end
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (sig_valid)
        begin
            tsf_q  <= tsf_runtime_val;
            len_q  <= pkt_len;
            rate_q <= pkt_rate;
            rssi_q <= rssi_half_db_lock_by_sig_valid;
            gpio_q <= gpio_status_lock_by_sig_valid;
        end
        if (trail_strobe)
            trail_q <= word_out;
    end

endmodule

`default_nettype wire

//--- tb_rx_intf.sv
// rx interface testbench with packet table, reference model of stream words and stream monitor
`timescale 1ns/1ps
`default_nettype none

module tb_rx_intf;
    import rx_intf_pkg::*;

    localparam int DRAIN_TIMEOUT = 4000;
    localparam int INTR_TIMEOUT  = 8;

    typedef struct packed {
        pkt_len_t   len;
        rate_t      rate;
        rssi_t      rssi;
        gpio_t      gpio;
        tsf_t       tsf;
        logic       fcs;
        logic       block;
        logic       ht;
        logic       keep;
        logic       bp;
        logic [7:0] cut;
    } pkt_t;

    logic     m00_axis_aclk;
    logic     rst_n;
    logic     pkt_header_valid;
    logic     pkt_header_valid_strobe;
    logic     ht_unsupport;
    rate_t    pkt_rate;
    pkt_len_t pkt_len;
    byte_t    byte_in;
    logic     byte_in_strobe;
    logic     fcs_in_strobe;
    logic     fcs_ok;
    logic     block_rx_dma_to_ps;
    logic     block_rx_dma_to_ps_valid;
    rssi_t    rssi_half_db_lock_by_sig_valid;
    gpio_t    gpio_status_lock_by_sig_valid;
    tsf_t     tsf_runtime_val;
    logic     keep_bad_fcs;
    logic     m00_axis_tvalid;
    word_t    m00_axis_tdata;
    logic     m00_axis_tlast;
    logic     m00_axis_tready;
    logic     rx_pkt_intr;

    pkt_t        table_q[$];
    logic [64:0] exp_q[$];
    logic [31:0] lfsr;
    logic        bp_on;
    sn_t         exp_sn;
    int          intr_count;
    int          intr_exp;
    int          word_count;
    string       cur_name;
    logic        hold_pending;
    logic [64:0] hold_word;

    rx_intf i_rx_intf (
        .m00_axis_aclk                  (m00_axis_aclk),
        .rst_n                          (rst_n),
        .pkt_header_valid               (pkt_header_valid),
        .pkt_header_valid_strobe        (pkt_header_valid_strobe),
        .ht_unsupport                   (ht_unsupport),
        .pkt_rate                       (pkt_rate),
        .pkt_len                        (pkt_len),
        .byte_in                        (byte_in),
        .byte_in_strobe                 (byte_in_strobe),
        .fcs_in_strobe                  (fcs_in_strobe),
        .fcs_ok                         (fcs_ok),
        .block_rx_dma_to_ps             (block_rx_dma_to_ps),
        .block_rx_dma_to_ps_valid       (block_rx_dma_to_ps_valid),
        .rssi_half_db_lock_by_sig_valid (rssi_half_db_lock_by_sig_valid),
        .gpio_status_lock_by_sig_valid  (gpio_status_lock_by_sig_valid),
        .tsf_runtime_val                (tsf_runtime_val),
        .keep_bad_fcs                   (keep_bad_fcs),
        .m00_axis_tvalid                (m00_axis_tvalid),
        .m00_axis_tdata                 (m00_axis_tdata),
        .m00_axis_tlast                 (m00_axis_tlast),
        .m00_axis_tready                (m00_axis_tready),
        .rx_pkt_intr                    (rx_pkt_intr)
    );

    initial
    begin
        m00_axis_aclk = 1'b0;
        forever
            #20 m00_axis_aclk = ~m00_axis_aclk;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [65:0] exp, input logic [65:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // strobes return to idle each cycle and tready follows the lfsr under back-pressure
    task automatic next_cycle;
        @(posedge m00_axis_aclk);
        #2;
        pkt_header_valid_strobe  = 1'b0;
        byte_in_strobe           = 1'b0;
        fcs_in_strobe            = 1'b0;
        block_rx_dma_to_ps_valid = 1'b0;
        block_rx_dma_to_ps       = 1'b0;
        m00_axis_tready          = 1'b1;
        if (bp_on)
            m00_axis_tready = (rand_bits(1) != 0);
    endtask

    task automatic add_pkt(input int len, input rate_t rate, input rssi_t rssi, input gpio_t gpio,
                           input tsf_t tsf, input logic fcs, input logic block, input logic ht,
                           input logic keep, input logic bp, input int cut);
        table_q.push_back({pkt_len_t'(len), rate, rssi, gpio, tsf, fcs, block, ht, keep, bp,
                           8'(cut)});
    endtask

    // drives one packet and builds its expected words alongside
    task automatic send_pkt(input pkt_t p);
        logic [64:0] words[$];
        word_t       acc;
        byte_t       b;
        logic        keep;
        int          nbytes;
        bp_on  = p.bp;
        keep   = !p.ht && !p.block && (p.cut == 0) && (p.fcs || p.keep);
        nbytes = (p.cut != 0) ? int'(p.cut) : int'(p.len);
        words.push_back({1'b0, p.tsf});
        words.push_back({1'b0, 21'd0, p.gpio, p.rssi, p.rate, p.len});
        next_cycle;
        tsf_runtime_val                = p.tsf;
        pkt_len                        = p.len;
        pkt_rate                       = p.rate;
        rssi_half_db_lock_by_sig_valid = p.rssi;
        gpio_status_lock_by_sig_valid  = p.gpio;
        ht_unsupport                   = p.ht;
        keep_bad_fcs                   = p.keep;
        pkt_header_valid               = 1'b1;
        pkt_header_valid_strobe        = 1'b1;
        next_cycle;
        next_cycle;
        block_rx_dma_to_ps_valid = 1'b1;
        block_rx_dma_to_ps       = p.block;
        acc = '0;
        for (int i = 0; i < nbytes; i++)
        begin
            next_cycle;
            b = byte_t'(rand_bits(8));
            byte_in        = b;
            byte_in_strobe = 1'b1;
            acc[8*(i%8) +: 8] = b;
            if (i % 8 == 7)
            begin
                words.push_back({1'b0, acc});
                acc = '0;
            end
            next_cycle;
        end
        // a cut packet is left open for the next signal field to kill
        if (p.cut == 0)
        begin
            if (p.len % 8 != 0)
                words.push_back({1'b0, acc});
            words.push_back({1'b1, 47'd0, p.fcs, exp_sn});
            next_cycle;
            next_cycle;
            fcs_in_strobe = 1'b1;
            fcs_ok        = p.fcs;
            if (keep)
            begin
                foreach (words[k])
                    exp_q.push_back(words[k]);
                exp_sn++;
                intr_exp++;
            end
            next_cycle;
        end
    endtask

    task automatic wait_delivered;
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            if (n == DRAIN_TIMEOUT)
                abort_run("timeout: expected stream words never arrived");
            else
            begin
                next_cycle;
                n++;
            end
        end
        n = 0;
        while (intr_count < intr_exp)
        begin
            if (n == INTR_TIMEOUT)
                abort_run("timeout: rx_pkt_intr did not pulse after the last word");
            else
            begin
                next_cycle;
                n++;
            end
        end
        check({cur_name, " intr count"}, intr_exp, intr_count);
    endtask

    // outputs are sampled mid-cycle so a handshake seen here completes at the next rising edge
    always @(negedge m00_axis_aclk)
    begin
        if (rst_n)
        begin
            if (hold_pending)
                check({cur_name, " hold"}, {1'b1, hold_word},
                      {m00_axis_tvalid, m00_axis_tlast, m00_axis_tdata});
            if (m00_axis_tvalid && m00_axis_tready)
            begin
                if (exp_q.size() == 0)
                    abort_run("a stream word was accepted while no word was expected");
                else
                begin
                    check($sformatf("%s word %0d", cur_name, word_count), exp_q.pop_front(),
                          {m00_axis_tlast, m00_axis_tdata});
                    word_count++;
                end
            end
            if (rx_pkt_intr)
                intr_count++;
            hold_pending = m00_axis_tvalid && !m00_axis_tready;
            hold_word    = {m00_axis_tlast, m00_axis_tdata};
        end
    end

    initial
    begin
        lfsr                           = 32'hc597;
        bp_on                          = 1'b0;
        exp_sn                         = '0;
        intr_count                     = 0;
        intr_exp                       = 0;
        word_count                     = 0;
        hold_pending                   = 1'b0;
        hold_word                      = '0;
        cur_name                       = "reset";
        rst_n                          = 1'b0;
        pkt_header_valid               = 1'b0;
        pkt_header_valid_strobe        = 1'b0;
        ht_unsupport                   = 1'b0;
        pkt_rate                       = '0;
        pkt_len                        = '0;
        byte_in                        = '0;
        byte_in_strobe                 = 1'b0;
        fcs_in_strobe                  = 1'b0;
        fcs_ok                         = 1'b0;
        block_rx_dma_to_ps             = 1'b0;
        block_rx_dma_to_ps_valid       = 1'b0;
        rssi_half_db_lock_by_sig_valid = '0;
        gpio_status_lock_by_sig_valid  = '0;
        tsf_runtime_val                = '0;
        keep_bad_fcs                   = 1'b0;
        m00_axis_tready                = 1'b1;

        // len rate rssi gpio tsf fcs block ht keep bp cut
        add_pkt(1,  8'h0b, 11'h155, 8'h3c, 64'h0000_0012_3456_789a, 1, 0, 0, 0, 0, 0);
        add_pkt(8,  8'h0f, 11'h2aa, 8'ha5, 64'h0000_0012_3456_9000, 1, 0, 0, 0, 0, 0);
        add_pkt(13, 8'h0a, 11'h7ff, 8'hff, 64'hffff_0000_1111_2222, 1, 0, 0, 0, 0, 0);
        add_pkt(64, 8'h0e, 11'h001, 8'h01, 64'h8000_0000_0000_0001, 1, 0, 0, 0, 0, 0);
        add_pkt(20, 8'h0b, 11'h0f0, 8'h11, 64'h0000_0000_0000_4000, 0, 0, 0, 0, 0, 0);
        add_pkt(20, 8'h09, 11'h30c, 8'h22, 64'h0000_0000_0000_5000, 0, 0, 0, 1, 0, 0);
        add_pkt(16, 8'h0d, 11'h123, 8'h33, 64'h0000_0000_0000_6000, 1, 1, 0, 0, 0, 0);
        add_pkt(10, 8'h80, 11'h456, 8'h44, 64'h0000_0000_0000_7000, 1, 0, 1, 0, 0, 0);
        add_pkt(9,  8'h08, 11'h0aa, 8'h55, 64'h0000_0000_0000_8000, 1, 0, 0, 0, 0, 0);
        add_pkt(64, 8'h0c, 11'h5a5, 8'h66, 64'h0123_4567_89ab_cdef, 1, 0, 0, 0, 1, 0);
        add_pkt(5,  8'h0f, 11'h00f, 8'h77, 64'hfedc_ba98_7654_3210, 1, 0, 0, 0, 1, 0);
        add_pkt(23, 8'h0a, 11'h3c3, 8'h88, 64'h0000_00ff_0000_00ff, 1, 0, 0, 0, 1, 0);
        add_pkt(30, 8'h0b, 11'h111, 8'h99, 64'h0000_0000_0000_c000, 1, 0, 0, 0, 0, 11);
        add_pkt(17, 8'h0e, 11'h222, 8'haa, 64'h0000_0000_0000_d000, 1, 0, 0, 0, 1, 0);
        add_pkt(3,  8'h0d, 11'h333, 8'hbb, 64'h0000_0000_0000_e000, 1, 0, 0, 0, 0, 0);

        repeat (4)
            next_cycle;
        rst_n = 1'b1;
        check("reset tvalid", 1'b0, m00_axis_tvalid);
        check("reset intr", 1'b0, rx_pkt_intr);

        foreach (table_q[i])
        begin
            cur_name = $sformatf("pkt %0d", i);
            send_pkt(table_q[i]);
            if (table_q[i].cut == 0)
            begin
                wait_delivered();
                repeat (4)
                    next_cycle;
            end
        end

        cur_name = "end of run";
        bp_on = 1'b0;
        repeat (20)
            next_cycle;
        check("final intr count", intr_exp, intr_count);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
